// ==== project.f ====
sd_dat_pkg.sv
sd_dat_fifo.sv
sd_dat_phys.sv
sd_dat_host.sv
sd_dat_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the SD DAT path testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module sd_dat_tb -o sd_dat_sim \
   && ./obj_dir/sd_dat_sim 2>&1 | tee sim.log \
   || { echo "Build or simulation run did not complete"; exit 1; }

grep -q "Test FAILED" sim.log && { echo "Simulation reported failure"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }

// ==== sd_dat_fifo.sv ====
/*
 * Synchronous first-word-fall-through FIFO
 * Holds the oldest word on rd_data, used for both transmit and receive
 */

`timescale 1ns/100ps

module sd_dat_fifo #(
   parameter int depth      = sd_dat_pkg::fifo_depth,
   parameter int addr_width = sd_dat_pkg::fifo_addr_width
) (
   input  logic                              sd_clk,
   input  logic                              rst_L,
   input  logic                              wr_enb,
   input  logic                              rd_enb,
   input  logic [sd_dat_pkg::fifo_width-1:0] wr_data,
   output logic [sd_dat_pkg::fifo_width-1:0] rd_data,
   output logic                              full,
   output logic                              empty
);

   logic [sd_dat_pkg::fifo_width-1:0] mem [depth];
   logic [addr_width-1:0]             wr_ptr;
   logic [addr_width-1:0]             rd_ptr;
   logic [addr_width:0]               count;
   logic                              wr_ok;
   logic                              rd_ok;

   // Depth is 2**addr_width so the top count bit marks full
   assign full  = count[addr_width];
   assign empty = (count == '0);

   assign wr_ok = wr_enb && !full;
   assign rd_ok = rd_enb && !empty;

   // Fall-through output
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge sd_clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   ////////////////////
   // Pointers and occupancy
   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== sd_dat_host.sv ====
/*
 * SD host DAT path top level
 * Transmit FIFO, DAT physical block and receive FIFO
 */

`timescale 1ns/100ps

module sd_dat_host (
   input  logic                                   sd_clk,
   input  logic                                   rst_L,
   input  logic                                   tx_wr_enb,
   input  logic                                   rx_rd_enb,
   input  logic                                   write_flag,
   input  logic                                   read_flag,
   input  logic [sd_dat_pkg::fifo_width-1:0]      tx_wr_data,
   input  logic [sd_dat_pkg::block_sz_width-1:0]  block_sz,
   input  logic [sd_dat_pkg::block_cnt_width-1:0] block_cnt,
   input  logic [3:0]                             dat_din,
   output logic                                   tx_full,
   output logic                                   rx_empty,
   output logic                                   dat_oe,
   output logic                                   busy,
   output logic                                   tf_finished,
   output logic                                   rx_overrun,
   output logic                                   end_err,
   output logic [sd_dat_pkg::fifo_width-1:0]      rx_rd_data,
   output logic [3:0]                             dat_dout
);

   // Transmit side
   logic [sd_dat_pkg::fifo_width-1:0] tx_buf_dout;
   logic                              tx_buf_rd_enb;
   logic                              tx_buf_empty;

   // Receive side
   logic [sd_dat_pkg::fifo_width-1:0] rx_buf_din;
   logic                              rx_buf_wr_enb;
   logic                              rx_full;

   ////////////////////
   // Host to card words
   sd_dat_fifo #(
      .depth      (sd_dat_pkg::fifo_depth),
      .addr_width (sd_dat_pkg::fifo_addr_width)
   ) tx_fifo_inst (
      .sd_clk  (sd_clk),
      .rst_L   (rst_L),
      .wr_enb  (tx_wr_enb),
      .rd_enb  (tx_buf_rd_enb),
      .wr_data (tx_wr_data),
      .rd_data (tx_buf_dout),
      .full    (tx_full),
      .empty   (tx_buf_empty)
   );

   sd_dat_phys dat_phys_inst (
      .sd_clk        (sd_clk),
      .rst_L         (rst_L),
      .write_flag    (write_flag),
      .read_flag     (read_flag),
      .tx_buf_empty  (tx_buf_empty),
      .rx_full       (rx_full),
      .tx_buf_dout   (tx_buf_dout),
      .dat_din       (dat_din),
      .block_sz      (block_sz),
      .block_cnt     (block_cnt),
      .tx_buf_rd_enb (tx_buf_rd_enb),
      .rx_buf_wr_enb (rx_buf_wr_enb),
      .dat_oe        (dat_oe),
      .busy          (busy),
      .tf_finished   (tf_finished),
      .rx_overrun    (rx_overrun),
      .end_err       (end_err),
      .rx_buf_din    (rx_buf_din),
      .dat_dout      (dat_dout)
   );

   ////////////////////
   // Card to host words
   sd_dat_fifo #(
      .depth      (sd_dat_pkg::fifo_depth),
      .addr_width (sd_dat_pkg::fifo_addr_width)
   ) rx_fifo_inst (
      .sd_clk  (sd_clk),
      .rst_L   (rst_L),
      .wr_enb  (rx_buf_wr_enb),
      .rd_enb  (rx_rd_enb),
      .wr_data (rx_buf_din),
      .rd_data (rx_rd_data),
      .full    (rx_full),
      .empty   (rx_empty)
   );

endmodule

// ==== sd_dat_phys.sv ====
/*
 * SD DAT line physical block, 4-bit bus mode
 * Serializes write blocks with start and end nibbles, waits out card busy,
 * and deserializes read blocks into 32-bit words for the receive FIFO
 */

`timescale 1ns/100ps

module sd_dat_phys (
   input  logic                                   sd_clk,
   input  logic                                   rst_L,
   input  logic                                   write_flag,
   input  logic                                   read_flag,
   input  logic                                   tx_buf_empty,
   input  logic                                   rx_full,
   input  logic [sd_dat_pkg::fifo_width-1:0]      tx_buf_dout,
   input  logic [3:0]                             dat_din,
   input  logic [sd_dat_pkg::block_sz_width-1:0]  block_sz,
   input  logic [sd_dat_pkg::block_cnt_width-1:0] block_cnt,
   output logic                                   tx_buf_rd_enb,
   output logic                                   rx_buf_wr_enb,
   output logic                                   dat_oe,
   output logic                                   busy,
   output logic                                   tf_finished,
   output logic                                   rx_overrun,
   output logic                                   end_err,
   output logic [sd_dat_pkg::fifo_width-1:0]      rx_buf_din,
   output logic [3:0]                             dat_dout
);

   ////////////////////
   // State registers
   logic [3:0]                                   state;
   logic [$clog2(sd_dat_pkg::nibbles_per_word)-1:0] nib_off;
   logic [sd_dat_pkg::block_sz_width:0]          nib_left;
   logic [sd_dat_pkg::block_cnt_width-1:0]       blocks_left;
   logic [sd_dat_pkg::block_sz_width-1:0]        blk_sz;
   logic [$bits(sd_dat_pkg::busy_guard)-1:0]     guard_cnt;
   logic [sd_dat_pkg::fifo_width-1:0]            tx_word;
   logic [sd_dat_pkg::fifo_width-1:0]            rx_shift;

   // Next values
   logic [3:0]                                   nxt_state;
   logic [$clog2(sd_dat_pkg::nibbles_per_word)-1:0] nxt_nib_off;
   logic [sd_dat_pkg::block_sz_width:0]          nxt_nib_left;
   logic [sd_dat_pkg::block_cnt_width-1:0]       nxt_blocks_left;
   logic [sd_dat_pkg::block_sz_width-1:0]        nxt_blk_sz;
   logic [$bits(sd_dat_pkg::busy_guard)-1:0]     nxt_guard_cnt;
   logic [sd_dat_pkg::fifo_width-1:0]            nxt_tx_word;
   logic [sd_dat_pkg::fifo_width-1:0]            nxt_rx_shift;
   logic [sd_dat_pkg::fifo_width-1:0]            nxt_rx_din;
   logic [3:0]                                   nxt_dat_dout;
   logic                                         nxt_dat_oe;
   logic                                         nxt_rx_wr_enb;
   logic                                         nxt_tf_finished;
   logic                                         nxt_rx_overrun;
   logic                                         nxt_end_err;

   assign busy = (state != sd_dat_pkg::st_idle);

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         state         <= sd_dat_pkg::st_idle;
         nib_off       <= '0;
         nib_left      <= '0;
         blocks_left   <= '0;
         blk_sz        <= '0;
         guard_cnt     <= '0;
         dat_dout      <= 4'hf;
         dat_oe        <= 1'b0;
         rx_buf_wr_enb <= 1'b0;
         tf_finished   <= 1'b0;
         rx_overrun    <= 1'b0;
         end_err       <= 1'b0;
      end else begin
         state         <= nxt_state;
         nib_off       <= nxt_nib_off;
         nib_left      <= nxt_nib_left;
         blocks_left   <= nxt_blocks_left;
         blk_sz        <= nxt_blk_sz;
         guard_cnt     <= nxt_guard_cnt;
         dat_dout      <= nxt_dat_dout;
         dat_oe        <= nxt_dat_oe;
         rx_buf_wr_enb <= nxt_rx_wr_enb;
         tf_finished   <= nxt_tf_finished;
         rx_overrun    <= nxt_rx_overrun;
         end_err       <= nxt_end_err;
      end
      // Data words
      tx_word    <= nxt_tx_word;
      rx_shift   <= nxt_rx_shift;
      rx_buf_din <= nxt_rx_din;
   end

   ////////////////////
   // Next state and outputs
   always_comb begin
      nxt_state       = state;
      nxt_nib_off     = nib_off;
      nxt_nib_left    = nib_left;
      nxt_blocks_left = blocks_left;
      nxt_blk_sz      = blk_sz;
      nxt_guard_cnt   = guard_cnt;
      nxt_tx_word     = tx_word;
      nxt_rx_shift    = rx_shift;
      nxt_rx_din      = rx_buf_din;
      nxt_dat_dout    = dat_dout;
      nxt_dat_oe      = dat_oe;
      tx_buf_rd_enb   = 1'b0;
      nxt_rx_wr_enb   = 1'b0;
      nxt_tf_finished = 1'b0;
      nxt_rx_overrun  = 1'b0;
      nxt_end_err     = 1'b0;

      case (state)
         sd_dat_pkg::st_idle: begin
            nxt_nib_off = '0;
            // Flags are still high while tf_finished shows, ignore them then
            if (!tf_finished) begin
               if (write_flag && !read_flag && dat_din[0]) begin
                  nxt_state       = sd_dat_pkg::st_wr_start;
                  nxt_dat_dout    = 4'h0;
                  nxt_dat_oe      = 1'b1;
                  nxt_blk_sz      = block_sz;
                  nxt_blocks_left = block_cnt;
               end else if (read_flag && !write_flag) begin
                  nxt_state       = sd_dat_pkg::st_rd_wait;
                  nxt_blk_sz      = block_sz;
                  nxt_blocks_left = block_cnt;
               end
            end
         end

         // Start nibble on the bus, first word of the block comes in here
         sd_dat_pkg::st_wr_start: begin
            tx_buf_rd_enb = !tx_buf_empty;
            nxt_tx_word   = tx_buf_dout;
            nxt_dat_dout  = tx_buf_dout[sd_dat_pkg::fifo_width-1 -: 4];
            nxt_nib_off   = nib_off + 1'b1;
            nxt_nib_left  = {blk_sz, 1'b0} - 1'b1;
            nxt_state     = sd_dat_pkg::st_wr_data;
         end

         sd_dat_pkg::st_wr_data: begin
            if (nib_left == '0) begin
               nxt_dat_dout = 4'hf;
               nxt_state    = sd_dat_pkg::st_wr_end;
            end else begin
               nxt_nib_left = nib_left - 1'b1;
               nxt_nib_off  = nib_off + 1'b1;
               if (nib_off == '0) begin
                  // Word boundary, fetch the next one
                  tx_buf_rd_enb = !tx_buf_empty;
                  nxt_tx_word   = tx_buf_dout;
                  nxt_dat_dout  = tx_buf_dout[sd_dat_pkg::fifo_width-1 -: 4];
               end else begin
                  nxt_dat_dout = tx_word[(sd_dat_pkg::fifo_width-1) - 4*nib_off -: 4];
               end
            end
         end

         sd_dat_pkg::st_wr_end: begin
            nxt_dat_oe      = 1'b0;
            nxt_guard_cnt   = sd_dat_pkg::busy_guard;
            nxt_blocks_left = blocks_left - 1'b1;
            nxt_state       = sd_dat_pkg::st_wr_busy;
         end

         // Guard cycles first, then hold until the card lets go of DAT0
         sd_dat_pkg::st_wr_busy: begin
            if (guard_cnt != '0) begin
               nxt_guard_cnt = guard_cnt - 1'b1;
            end else if (dat_din[0]) begin
               if (blocks_left != '0) begin
                  nxt_state    = sd_dat_pkg::st_wr_start;
                  nxt_dat_dout = 4'h0;
                  nxt_dat_oe   = 1'b1;
               end else begin
                  nxt_tf_finished = 1'b1;
                  nxt_state       = sd_dat_pkg::st_idle;
               end
            end
         end

         sd_dat_pkg::st_rd_wait: begin
            if (dat_din == 4'h0) begin
               nxt_nib_off  = '0;
               nxt_nib_left = {blk_sz, 1'b0} - 1'b1;
               nxt_state    = sd_dat_pkg::st_rd_data;
            end
         end

         sd_dat_pkg::st_rd_data: begin
            nxt_rx_shift = {rx_shift[sd_dat_pkg::fifo_width-5:0], dat_din};
            nxt_nib_off  = nib_off + 1'b1;
            if (&nib_off) begin
               // Full word, dropped when the receive FIFO has no room
               nxt_rx_din     = {rx_shift[sd_dat_pkg::fifo_width-5:0], dat_din};
               nxt_rx_wr_enb  = !rx_full;
               nxt_rx_overrun = rx_full;
            end
            if (nib_left == '0) begin
               nxt_state = sd_dat_pkg::st_rd_end;
            end else begin
               nxt_nib_left = nib_left - 1'b1;
            end
         end

         sd_dat_pkg::st_rd_end: begin
            nxt_end_err     = (dat_din != 4'hf);
            nxt_blocks_left = blocks_left - 1'b1;
            if (nxt_blocks_left == '0) begin
               nxt_tf_finished = 1'b1;
               nxt_state       = sd_dat_pkg::st_idle;
            end else begin
               nxt_state = sd_dat_pkg::st_rd_wait;
            end
         end

         default: begin
            nxt_state  = sd_dat_pkg::st_idle;
            nxt_dat_oe = 1'b0;
         end
      endcase
   end

endmodule

// ==== sd_dat_pkg.sv ====
/*
 * SD host DAT line shared constants
 * Bus widths, FIFO sizing, busy guard and the DAT FSM state codes
 */

package sd_dat_pkg;

   ////////////////////
   // Data path widths
   localparam int fifo_width       = 32;
   localparam int nibbles_per_word = 8;

   // FIFO sizing, depth must stay a power of two
   localparam int fifo_depth      = 32;
   localparam int fifo_addr_width = 5;

   // Block size in bytes and blocks per transfer
   localparam int block_sz_width  = 10;
   localparam int block_cnt_width = 8;

   // Cycles after the end nibble before DAT0 busy is sampled
   localparam logic [1:0] busy_guard = 2'd2;

   ////////////////////
   // DAT FSM state codes
   localparam logic [3:0] st_idle     = 4'd0;
   localparam logic [3:0] st_wr_start = 4'd1;
   localparam logic [3:0] st_wr_data  = 4'd2;
   localparam logic [3:0] st_wr_end   = 4'd3;
   localparam logic [3:0] st_wr_busy  = 4'd4;
   localparam logic [3:0] st_rd_wait  = 4'd5;
   localparam logic [3:0] st_rd_data  = 4'd6;
   localparam logic [3:0] st_rd_end   = 4'd7;

endpackage

// ==== sd_dat_tb.sv ====
/*
 * Testbench for the SD host DAT path
 * Card model on DAT, queue model of the expected words, write and read checks
 */

`timescale 1ns/100ps

module sd_dat_tb;

   localparam int max_cycles = 20000;

   logic                                   sd_clk;
   logic                                   rst_L;
   logic                                   tx_wr_enb;
   logic                                   rx_rd_enb;
   logic                                   write_flag;
   logic                                   read_flag;
   logic [sd_dat_pkg::fifo_width-1:0]      tx_wr_data;
   logic [sd_dat_pkg::block_sz_width-1:0]  block_sz;
   logic [sd_dat_pkg::block_cnt_width-1:0] block_cnt;
   logic [3:0]                             dat_din;
   logic                                   tx_full;
   logic                                   rx_empty;
   logic                                   dat_oe;
   logic                                   busy;
   logic                                   tf_finished;
   logic                                   rx_overrun;
   logic                                   end_err;
   logic [sd_dat_pkg::fifo_width-1:0]      rx_rd_data;
   logic [3:0]                             dat_dout;

   int errors;
   int cycles;
   int fin_cnt;
   int overrun_cnt;
   int end_err_cnt;
   logic [sd_dat_pkg::fifo_width-1:0] exp_q [$];

   sd_dat_host sd_dat_host_inst (
      .sd_clk      (sd_clk),
      .rst_L       (rst_L),
      .tx_wr_enb   (tx_wr_enb),
      .rx_rd_enb   (rx_rd_enb),
      .write_flag  (write_flag),
      .read_flag   (read_flag),
      .tx_wr_data  (tx_wr_data),
      .block_sz    (block_sz),
      .block_cnt   (block_cnt),
      .dat_din     (dat_din),
      .tx_full     (tx_full),
      .rx_empty    (rx_empty),
      .dat_oe      (dat_oe),
      .busy        (busy),
      .tf_finished (tf_finished),
      .rx_overrun  (rx_overrun),
      .end_err     (end_err),
      .rx_rd_data  (rx_rd_data),
      .dat_dout    (dat_dout)
   );

   initial begin
      sd_clk = 1'b0;
      forever #50 sd_clk = ~sd_clk;
   end

   // Pulse counters sampled on the rising edge
   always @(posedge sd_clk) begin
      if (rst_L) begin
         if (tf_finished) begin
            fin_cnt++;
         end
         if (rx_overrun) begin
            overrun_cnt++;
         end
         if (end_err) begin
            end_err_cnt++;
         end
      end
   end

   initial begin
      cycles = 0;
      while (cycles < max_cycles) begin
         @(posedge sd_clk);
         cycles++;
      end
      $display("ERROR: run stopped by timeout after %0d cycles", cycles);
      $display("Errors: %0d", errors + 1);
      $display("Test FAILED");
      $finish;
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic load_words(input int n);
      logic [31:0] w;
      for (int i = 0; i < n; i++) begin
         w = $urandom();
         @(posedge sd_clk);
         tx_wr_enb  <= 1'b1;
         tx_wr_data <= w;
         exp_q.push_back(w);
      end
      @(posedge sd_clk);
      tx_wr_enb <= 1'b0;
   endtask

   task automatic issue_write(input int bs, input int bc);
      int n;
      n = bc * bs / 4;
      load_words(n);
      @(negedge sd_clk);
      compare_value("tx_full", tx_full, n >= sd_dat_pkg::fifo_depth);
      @(posedge sd_clk);
      write_flag <= 1'b1;
      block_sz   <= bs[sd_dat_pkg::block_sz_width-1:0];
      block_cnt  <= bc[sd_dat_pkg::block_cnt_width-1:0];
   endtask

   task automatic wait_oe(output int lat);
      lat = 0;
      do begin
         @(negedge sd_clk);
         lat++;
      end while (!dat_oe);
   endtask

   task automatic wait_finished();
      do begin
         @(negedge sd_clk);
      end while (!tf_finished);
   endtask

   ////////////////////
   // Card side of a write transfer
   task automatic run_write(input int bs, input int bc);
      int lat;
      int hold;
      int fin_before;
      logic [31:0] word;
      fin_before = fin_cnt;
      for (int b = 0; b < bc; b++) begin
         // Start nibble one cycle after the DUT sees DAT0 high
         wait_oe(lat);
         compare_value("start latency", lat, 2);
         compare_value("start nibble", dat_dout, 4'h0);
         compare_value("busy", busy, 1'b1);
         word = '0;
         for (int k = 0; k < 2 * bs; k++) begin
            @(negedge sd_clk);
            compare_value("dat_oe", dat_oe, 1'b1);
            word = {word[27:0], dat_dout};
            if (k % 8 == 7) begin
               compare_value("dat_dout word", word, exp_q.pop_front());
            end
         end
         @(negedge sd_clk);
         compare_value("end nibble", dat_dout, 4'hf);
         compare_value("dat_oe", dat_oe, 1'b1);
         // Card programs the block and holds DAT0 low
         hold = int'(sd_dat_pkg::busy_guard) + $urandom_range(0, 10);
         @(posedge sd_clk);
         dat_din <= 4'he;
         repeat (hold) begin
            @(negedge sd_clk);
            compare_value("dat_oe while card busy", dat_oe, 1'b0);
            compare_value("busy", busy, 1'b1);
            @(posedge sd_clk);
         end
         dat_din <= 4'hf;
      end
      wait_finished();
      @(posedge sd_clk);
      write_flag <= 1'b0;
      @(negedge sd_clk);
      compare_value("tf_finished pulses", fin_cnt - fin_before, 1);
      compare_value("words left", exp_q.size(), 0);
   endtask

   ////////////////////
   // Card side of a read transfer
   task automatic send_blocks(input int bs, input int bc, input int bad_blk);
      logic [31:0] word;
      for (int b = 0; b < bc; b++) begin
         repeat ($urandom_range(2, 10)) @(posedge sd_clk);
         dat_din <= 4'h0;
         for (int w = 0; w < bs / 4; w++) begin
            word = $urandom();
            exp_q.push_back(word);
            for (int k = 7; k >= 0; k--) begin
               @(posedge sd_clk);
               dat_din <= word[4*k +: 4];
            end
         end
         @(posedge sd_clk);
         dat_din <= (b == bad_blk) ? 4'h5 : 4'hf;
         @(posedge sd_clk);
         dat_din <= 4'hf;
      end
   endtask

   task automatic drain_words(input int n);
      int got;
      got = 0;
      while (got < n) begin
         @(negedge sd_clk);
         if (!rx_empty) begin
            compare_value("rx_rd_data", rx_rd_data, exp_q.pop_front());
            got++;
            @(posedge sd_clk);
            rx_rd_enb <= 1'b1;
            @(posedge sd_clk);
            rx_rd_enb <= 1'b0;
         end
      end
   endtask

   task automatic run_read(input int bs, input int bc, input int bad_blk, input bit drain);
      int total;
      int kept;
      int fin_before;
      int ovr_before;
      int err_before;
      total      = bc * bs / 4;
      kept       = (total > sd_dat_pkg::fifo_depth) ? sd_dat_pkg::fifo_depth : total;
      fin_before = fin_cnt;
      ovr_before = overrun_cnt;
      err_before = end_err_cnt;
      @(posedge sd_clk);
      read_flag <= 1'b1;
      block_sz  <= bs[sd_dat_pkg::block_sz_width-1:0];
      block_cnt <= bc[sd_dat_pkg::block_cnt_width-1:0];
      fork
         begin
            send_blocks(bs, bc, bad_blk);
            wait_finished();
            @(posedge sd_clk);
            read_flag <= 1'b0;
         end
         begin
            if (drain) begin
               drain_words(total);
            end
         end
      join
      if (!drain) begin
         drain_words(kept);
      end
      @(negedge sd_clk);
      compare_value("rx_empty", rx_empty, 1'b1);
      compare_value("tf_finished pulses", fin_cnt - fin_before, 1);
      compare_value("rx_overrun pulses", overrun_cnt - ovr_before, drain ? 0 : total - kept);
      compare_value("end_err pulses", end_err_cnt - err_before, (bad_blk >= 0) ? 1 : 0);
      exp_q.delete();
   endtask

   ////////////////////
   // Main sequence
   initial begin
      int bs;
      int bc;
      void'($urandom(58));
      errors      = 0;
      fin_cnt     = 0;
      overrun_cnt = 0;
      end_err_cnt = 0;
      rst_L       = 1'b0;
      tx_wr_enb   = 1'b0;
      rx_rd_enb   = 1'b0;
      write_flag  = 1'b0;
      read_flag   = 1'b0;
      tx_wr_data  = '0;
      block_sz    = '0;
      block_cnt   = '0;
      dat_din     = 4'hf;
      repeat (7) @(posedge sd_clk);
      @(negedge sd_clk);
      compare_value("dat_oe after reset", dat_oe, 1'b0);
      compare_value("dat_dout after reset", dat_dout, 4'hf);
      compare_value("busy after reset", busy, 1'b0);
      compare_value("tf_finished after reset", tf_finished, 1'b0);
      compare_value("rx_overrun after reset", rx_overrun, 1'b0);
      compare_value("end_err after reset", end_err, 1'b0);
      @(posedge sd_clk);
      rst_L <= 1'b1;

      // Single block
      bs = 4 * $urandom_range(1, 8);
      issue_write(bs, 1);
      run_write(bs, 1);

      // Multi-block writes with card busy between blocks
      for (int t = 0; t < 8; t++) begin
         bs = 4 * $urandom_range(1, 8);
         bc = $urandom_range(1, 4);
         issue_write(bs, bc);
         run_write(bs, bc);
      end

      // Card busy in idle holds off the start nibble
      // Transfer fills the whole transmit FIFO
      @(posedge sd_clk);
      dat_din <= 4'he;
      issue_write(32, 4);
      repeat (20) begin
         @(negedge sd_clk);
         compare_value("dat_oe while card busy", dat_oe, 1'b0);
      end
      @(posedge sd_clk);
      dat_din <= 4'hf;
      run_write(32, 4);

      // Reads with the host draining
      for (int t = 0; t < 4; t++) begin
         bs = 4 * $urandom_range(1, 16);
         bc = $urandom_range(1, 4);
         run_read(bs, bc, -1, 1'b1);
      end

      // Bad end nibble on the second block
      run_read(16, 3, 1, 1'b1);

      // 48 words into a 32 word FIFO that nobody reads
      run_read(64, 3, -1, 1'b0);

      repeat (4) @(posedge sd_clk);
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule
